/* design/stream_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream switch field widths, input count and packet buffer geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package stream_pkg;

    // Sample bits carried by every beat
    localparam int DATA_WIDTH = 16;

    // Destination tag, only bit 0 is used by the router
    localparam int DEST_WIDTH = 8;

    // Sideband user bits, passed through untouched
    localparam int USER_WIDTH = 8;

    // The multiplexer has four stream inputs picked by a 2-bit select
    localparam int N_INPUTS = 4;
    localparam int SELECT_WIDTH = 2;

    // Buffer between the multiplexer and the router
    localparam int FIFO_DEPTH = 8;

    // Pointer width for the circular buffer, the depth is a power of two
    localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // The occupancy counter needs one extra code for the full state
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [FIFO_COUNT_WIDTH-1:0] FIFO_FULL_COUNT = FIFO_COUNT_WIDTH'(FIFO_DEPTH);

endpackage

/* design/control_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control encodings for the multiplexer FSM and the packet router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package control_pkg;

    // Multiplexer state
    // In idle the select port is followed, inside a packet the latched
    // select is held until the beat with tlast has transferred
    typedef enum logic {
        MUX_IDLE   = 1'b0,
        MUX_PACKET = 1'b1
    } mux_state_t;

    // Output chosen by the router for the packet in flight
    // The encoding matches bit 0 of the dest field
    typedef enum logic {
        ROUTE_OUT0 = 1'b0,
        ROUTE_OUT1 = 1'b1
    } route_t;

endpackage

/* design/axi_stream.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Stream link with data, dest, user, tlast and valid/ready handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface axi_stream;

    // Payload of one beat
    logic [stream_pkg::DATA_WIDTH-1:0] data;
    logic [stream_pkg::DEST_WIDTH-1:0] dest;
    logic [stream_pkg::USER_WIDTH-1:0] user;

    // Marks the last beat of a packet
    logic tlast;

    // A beat moves on a rising clock when both of these are high
    logic valid;
    logic ready;

    // The source side drives the payload and valid
    modport master (
        output data,
        output dest,
        output user,
        output tlast,
        output valid,
        input  ready
    );

    // The sink side only drives ready back
    modport slave (
        input  data,
        input  dest,
        input  user,
        input  tlast,
        input  valid,
        output ready
    );

endinterface

/* design/axi_stream_mux_4.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered 4-to-1 stream multiplexer, switches only between packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axi_stream_mux_4 (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [stream_pkg::SELECT_WIDTH-1:0] select,
    axi_stream.slave                            stream_in_1,
    axi_stream.slave                            stream_in_2,
    axi_stream.slave                            stream_in_3,
    axi_stream.slave                            stream_in_4,
    axi_stream.master                           stream_out
);

    // Inputs gathered into arrays so the selected one can be indexed
    logic [stream_pkg::DATA_WIDTH-1:0] in_data  [stream_pkg::N_INPUTS];
    logic [stream_pkg::DEST_WIDTH-1:0] in_dest  [stream_pkg::N_INPUTS];
    logic [stream_pkg::USER_WIDTH-1:0] in_user  [stream_pkg::N_INPUTS];
    logic [stream_pkg::N_INPUTS-1:0]   in_tlast;
    logic [stream_pkg::N_INPUTS-1:0]   in_valid;
    logic [stream_pkg::N_INPUTS-1:0]   in_ready;

    control_pkg::mux_state_t           state;
    logic [stream_pkg::SELECT_WIDTH-1:0] latched_select;
    logic [stream_pkg::SELECT_WIDTH-1:0] current_select;
    logic                              can_load;
    logic                              in_transfer;

    assign in_data[0] = stream_in_1.data;
    assign in_data[1] = stream_in_2.data;
    assign in_data[2] = stream_in_3.data;
    assign in_data[3] = stream_in_4.data;
    assign in_dest[0] = stream_in_1.dest;
    assign in_dest[1] = stream_in_2.dest;
    assign in_dest[2] = stream_in_3.dest;
    assign in_dest[3] = stream_in_4.dest;
    assign in_user[0] = stream_in_1.user;
    assign in_user[1] = stream_in_2.user;
    assign in_user[2] = stream_in_3.user;
    assign in_user[3] = stream_in_4.user;
    assign in_tlast   = {stream_in_4.tlast, stream_in_3.tlast, stream_in_2.tlast, stream_in_1.tlast};
    assign in_valid   = {stream_in_4.valid, stream_in_3.valid, stream_in_2.valid, stream_in_1.valid};

    assign stream_in_1.ready = in_ready[0];
    assign stream_in_2.ready = in_ready[1];
    assign stream_in_3.ready = in_ready[2];
    assign stream_in_4.ready = in_ready[3];

    // Between packets the select port is followed directly
    // Inside a packet the input that started it stays connected
    assign current_select = (state == control_pkg::MUX_IDLE) ? select : latched_select;

    // The output register can take a new beat when it is empty or draining
    assign can_load = !stream_out.valid || stream_out.ready;

    // Only the connected input ever sees ready, and only once it offers a beat
    always_comb begin
        in_ready = '0;
        in_ready[current_select] = can_load && in_valid[current_select];
    end

    assign in_transfer = in_valid[current_select] && in_ready[current_select];

    // Packet tracking FSM
    always_ff @(posedge clock) begin
        if (!reset) begin
            state          <= control_pkg::MUX_IDLE;
            latched_select <= '0;
        end else if (in_transfer) begin
            // The first beat of a packet pins the select
            if (state == control_pkg::MUX_IDLE) begin
                latched_select <= select;
            end
            // Single-beat packets never leave idle
            if (in_tlast[current_select]) begin
                state <= control_pkg::MUX_IDLE;
            end else begin
                state <= control_pkg::MUX_PACKET;
            end
        end
    end

    // Output valid is control state and is cleared by reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_out.valid <= 1'b0;
        end else if (can_load) begin
            stream_out.valid <= in_transfer;
        end
    end

    // Payload register, loaded only when a beat is accepted
    always_ff @(posedge clock) begin
        if (in_transfer) begin
            stream_out.data  <= in_data[current_select];
            stream_out.dest  <= in_dest[current_select];
            stream_out.user  <= in_user[current_select];
            stream_out.tlast <= in_tlast[current_select];
        end
    end

endmodule

/* design/stream_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous first-word-fall-through FIFO for whole stream beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_fifo (
    input  logic      clock,
    input  logic      reset,
    axi_stream.slave  stream_in,
    axi_stream.master stream_out
);

    // Storage, one slot per field so a beat is kept whole
    logic [stream_pkg::DATA_WIDTH-1:0] mem_data  [stream_pkg::FIFO_DEPTH];
    logic [stream_pkg::DEST_WIDTH-1:0] mem_dest  [stream_pkg::FIFO_DEPTH];
    logic [stream_pkg::USER_WIDTH-1:0] mem_user  [stream_pkg::FIFO_DEPTH];
    logic                              mem_tlast [stream_pkg::FIFO_DEPTH];

    logic [stream_pkg::FIFO_ADDR_WIDTH-1:0]  write_pointer;
    logic [stream_pkg::FIFO_ADDR_WIDTH-1:0]  read_pointer;
    logic [stream_pkg::FIFO_COUNT_WIDTH-1:0] count;

    logic write_enable;
    logic read_enable;

    // Back-pressure to the multiplexer only when every slot is taken
    assign stream_in.ready = (count != stream_pkg::FIFO_FULL_COUNT);

    // Not empty means the head slot holds a beat
    assign stream_out.valid = (count != '0);

    // Head entry falls straight through to the output
    assign stream_out.data  = mem_data[read_pointer];
    assign stream_out.dest  = mem_dest[read_pointer];
    assign stream_out.user  = mem_user[read_pointer];
    assign stream_out.tlast = mem_tlast[read_pointer];

    assign write_enable = stream_in.valid && stream_in.ready;
    assign read_enable  = stream_out.valid && stream_out.ready;

    // Memory write port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem_data[write_pointer]  <= stream_in.data;
            mem_dest[write_pointer]  <= stream_in.dest;
            mem_user[write_pointer]  <= stream_in.user;
            mem_tlast[write_pointer] <= stream_in.tlast;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (write_enable) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (read_enable) begin
                read_pointer <= read_pointer + 1'b1;
            end
            // Simultaneous read and write leave the occupancy unchanged
            case ({write_enable, read_enable})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/stream_dest_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet router, steers each whole packet to one of two outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_dest_router (
    input  logic      clock,
    input  logic      reset,
    axi_stream.slave  stream_in,
    axi_stream.master stream_out_0,
    axi_stream.master stream_out_1
);

    control_pkg::route_t route_held;
    control_pkg::route_t route_now;
    logic                in_packet;
    logic                in_transfer;

    // First beat decides from dest bit 0, later beats reuse the held route
    always_comb begin
        if (in_packet) begin
            route_now = route_held;
        end else if (stream_in.dest[0]) begin
            route_now = control_pkg::ROUTE_OUT1;
        end else begin
            route_now = control_pkg::ROUTE_OUT0;
        end
    end

    // Payload goes to both sides, valid marks the one that owns it
    assign stream_out_0.data  = stream_in.data;
    assign stream_out_0.dest  = stream_in.dest;
    assign stream_out_0.user  = stream_in.user;
    assign stream_out_0.tlast = stream_in.tlast;
    assign stream_out_1.data  = stream_in.data;
    assign stream_out_1.dest  = stream_in.dest;
    assign stream_out_1.user  = stream_in.user;
    assign stream_out_1.tlast = stream_in.tlast;

    assign stream_out_0.valid = stream_in.valid && (route_now == control_pkg::ROUTE_OUT0);
    assign stream_out_1.valid = stream_in.valid && (route_now == control_pkg::ROUTE_OUT1);

    // The idle output's ready must not release a beat
    assign stream_in.ready = (route_now == control_pkg::ROUTE_OUT1) ? stream_out_1.ready
                                                                     : stream_out_0.ready;

    assign in_transfer = stream_in.valid && stream_in.ready;

    // Route is pinned on each transfer and released by tlast
    always_ff @(posedge clock) begin
        if (!reset) begin
            in_packet  <= 1'b0;
            route_held <= control_pkg::ROUTE_OUT0;
        end else if (in_transfer) begin
            route_held <= route_now;
            in_packet  <= !stream_in.tlast;
        end
    end

endmodule

/* design/stream_switch_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream switch top level, four inputs through mux, FIFO and router
// to two destination outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_switch_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [stream_pkg::SELECT_WIDTH-1:0] select,
    input  logic [stream_pkg::DATA_WIDTH-1:0]   in0_data,
    input  logic [stream_pkg::DEST_WIDTH-1:0]   in0_dest,
    input  logic [stream_pkg::USER_WIDTH-1:0]   in0_user,
    input  logic                                in0_tlast,
    input  logic                                in0_valid,
    output logic                                in0_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0]   in1_data,
    input  logic [stream_pkg::DEST_WIDTH-1:0]   in1_dest,
    input  logic [stream_pkg::USER_WIDTH-1:0]   in1_user,
    input  logic                                in1_tlast,
    input  logic                                in1_valid,
    output logic                                in1_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0]   in2_data,
    input  logic [stream_pkg::DEST_WIDTH-1:0]   in2_dest,
    input  logic [stream_pkg::USER_WIDTH-1:0]   in2_user,
    input  logic                                in2_tlast,
    input  logic                                in2_valid,
    output logic                                in2_ready,
    input  logic [stream_pkg::DATA_WIDTH-1:0]   in3_data,
    input  logic [stream_pkg::DEST_WIDTH-1:0]   in3_dest,
    input  logic [stream_pkg::USER_WIDTH-1:0]   in3_user,
    input  logic                                in3_tlast,
    input  logic                                in3_valid,
    output logic                                in3_ready,
    output logic [stream_pkg::DATA_WIDTH-1:0]   out0_data,
    output logic [stream_pkg::DEST_WIDTH-1:0]   out0_dest,
    output logic [stream_pkg::USER_WIDTH-1:0]   out0_user,
    output logic                                out0_tlast,
    output logic                                out0_valid,
    input  logic                                out0_ready,
    output logic [stream_pkg::DATA_WIDTH-1:0]   out1_data,
    output logic [stream_pkg::DEST_WIDTH-1:0]   out1_dest,
    output logic [stream_pkg::USER_WIDTH-1:0]   out1_user,
    output logic                                out1_tlast,
    output logic                                out1_valid,
    input  logic                                out1_ready
);

    // One link per multiplexer input, then one per pipeline hop
    axi_stream mux_in [stream_pkg::N_INPUTS] ();
    axi_stream mux_to_fifo ();
    axi_stream fifo_to_router ();
    axi_stream router_out0 ();
    axi_stream router_out1 ();

    // Plain input ports onto the multiplexer links
    assign mux_in[0].data  = in0_data;
    assign mux_in[0].dest  = in0_dest;
    assign mux_in[0].user  = in0_user;
    assign mux_in[0].tlast = in0_tlast;
    assign mux_in[0].valid = in0_valid;
    assign in0_ready       = mux_in[0].ready;
    assign mux_in[1].data  = in1_data;
    assign mux_in[1].dest  = in1_dest;
    assign mux_in[1].user  = in1_user;
    assign mux_in[1].tlast = in1_tlast;
    assign mux_in[1].valid = in1_valid;
    assign in1_ready       = mux_in[1].ready;
    assign mux_in[2].data  = in2_data;
    assign mux_in[2].dest  = in2_dest;
    assign mux_in[2].user  = in2_user;
    assign mux_in[2].tlast = in2_tlast;
    assign mux_in[2].valid = in2_valid;
    assign in2_ready       = mux_in[2].ready;
    assign mux_in[3].data  = in3_data;
    assign mux_in[3].dest  = in3_dest;
    assign mux_in[3].user  = in3_user;
    assign mux_in[3].tlast = in3_tlast;
    assign mux_in[3].valid = in3_valid;
    assign in3_ready       = mux_in[3].ready;

    // Router links onto the plain output ports
    assign out0_data         = router_out0.data;
    assign out0_dest         = router_out0.dest;
    assign out0_user         = router_out0.user;
    assign out0_tlast        = router_out0.tlast;
    assign out0_valid        = router_out0.valid;
    assign router_out0.ready = out0_ready;
    assign out1_data         = router_out1.data;
    assign out1_dest         = router_out1.dest;
    assign out1_user         = router_out1.user;
    assign out1_tlast        = router_out1.tlast;
    assign out1_valid        = router_out1.valid;
    assign router_out1.ready = out1_ready;

    axi_stream_mux_4 u_axi_stream_mux_4 (
        .clock       (clock),
        .reset       (reset),
        .select      (select),
        .stream_in_1 (mux_in[0]),
        .stream_in_2 (mux_in[1]),
        .stream_in_3 (mux_in[2]),
        .stream_in_4 (mux_in[3]),
        .stream_out  (mux_to_fifo)
    );

    stream_fifo u_stream_fifo (
        .clock      (clock),
        .reset      (reset),
        .stream_in  (mux_to_fifo),
        .stream_out (fifo_to_router)
    );

    stream_dest_router u_stream_dest_router (
        .clock        (clock),
        .reset        (reset),
        .stream_in    (fifo_to_router),
        .stream_out_0 (router_out0),
        .stream_out_1 (router_out1)
    );

endmodule

/* tests/stream_switch_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake properties of the stream switch, bound to its top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_switch_properties (
    input logic                              clock,
    input logic                              reset,
    input logic                              in0_tlast, in1_tlast, in2_tlast, in3_tlast,
    input logic                              in0_valid, in1_valid, in2_valid, in3_valid,
    input logic                              in0_ready, in1_ready, in2_ready, in3_ready,
    input logic [stream_pkg::DATA_WIDTH-1:0] out0_data, out1_data,
    input logic [stream_pkg::DEST_WIDTH-1:0] out0_dest, out1_dest,
    input logic [stream_pkg::USER_WIDTH-1:0] out0_user, out1_user,
    input logic                              out0_tlast, out1_tlast,
    input logic                              out0_valid, out1_valid,
    input logic                              out0_ready, out1_ready
);

    logic [stream_pkg::N_INPUTS-1:0]     in_ready;
    logic [stream_pkg::N_INPUTS-1:0]     in_take;
    logic [stream_pkg::N_INPUTS-1:0]     in_last;
    logic [stream_pkg::N_INPUTS-1:0]     other_ready;
    logic [stream_pkg::SELECT_WIDTH-1:0] packet_src;
    control_pkg::mux_state_t             state;
    int                                  in_flight;

    assign in_ready = {in3_ready, in2_ready, in1_ready, in0_ready};
    assign in_take  = in_ready & {in3_valid, in2_valid, in1_valid, in0_valid};
    assign in_last  = {in3_tlast, in2_tlast, in1_tlast, in0_tlast};

    // Readys of every input except the one that owns the packet
    always_comb begin
        other_ready = in_ready;
        other_ready[packet_src] = 1'b0;
    end

    // Packet owner seen from the input handshakes, plus beats held inside
    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= control_pkg::MUX_IDLE;
            packet_src <= '0;
            in_flight  <= 0;
        end else begin
            for (int i = 0; i < stream_pkg::N_INPUTS; i++) begin
                if (in_take[i]) begin
                    packet_src <= stream_pkg::SELECT_WIDTH'(i);
                    state      <= in_last[i] ? control_pkg::MUX_IDLE : control_pkg::MUX_PACKET;
                end
            end
            in_flight <= in_flight + $countones(in_take)
                         - int'(out0_valid && out0_ready) - int'(out1_valid && out1_ready);
        end
    end

    out0_stable: assert property (@(posedge clock) disable iff (!reset)
        out0_valid && !out0_ready |=>
            out0_valid && $stable({out0_data, out0_dest, out0_user, out0_tlast}))
        else $error("output 0 beat changed while stalled");

    out1_stable: assert property (@(posedge clock) disable iff (!reset)
        out1_valid && !out1_ready |=>
            out1_valid && $stable({out1_data, out1_dest, out1_user, out1_tlast}))
        else $error("output 1 beat changed while stalled");

    quiet_after_reset: assert property (@(posedge clock)
        !reset |=> !out0_valid && !out1_valid)
        else $error("output valid high after reset");

    locked_inputs: assert property (@(posedge clock) disable iff (!reset)
        state == control_pkg::MUX_PACKET |-> other_ready == '0)
        else $error("unselected input ready inside a packet");

    // One beat in the mux register plus a full FIFO is the most held
    bounded_occupancy: assert property (@(posedge clock) disable iff (!reset)
        in_flight >= 0 && in_flight <= stream_pkg::FIFO_DEPTH + 1)
        else $error("beats lost or created inside the switch");

endmodule

bind stream_switch_top stream_switch_properties u_stream_switch_properties (.*);

/* tests/stream_switch_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream switch testbench, random packets on four inputs with output
// back-pressure, checked against one scoreboard queue per output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_switch_tb;

    // One beat packed as data, dest, user and tlast, so tlast is bit 0
    // and dest bit 0 sits just above the user field
    typedef logic [stream_pkg::DATA_WIDTH+stream_pkg::DEST_WIDTH+stream_pkg::USER_WIDTH:0] beat_t;

    logic clock;
    logic reset;
    logic [stream_pkg::SELECT_WIDTH-1:0] select;

    // DUT ports, named as on the top level
    logic [stream_pkg::DATA_WIDTH-1:0] in0_data, in1_data, in2_data, in3_data;
    logic [stream_pkg::DEST_WIDTH-1:0] in0_dest, in1_dest, in2_dest, in3_dest;
    logic [stream_pkg::USER_WIDTH-1:0] in0_user, in1_user, in2_user, in3_user;
    logic in0_tlast, in1_tlast, in2_tlast, in3_tlast;
    logic in0_valid, in1_valid, in2_valid, in3_valid;
    logic in0_ready, in1_ready, in2_ready, in3_ready;
    logic [stream_pkg::DATA_WIDTH-1:0] out0_data, out1_data;
    logic [stream_pkg::DEST_WIDTH-1:0] out0_dest, out1_dest;
    logic [stream_pkg::USER_WIDTH-1:0] out0_user, out1_user;
    logic out0_tlast, out1_tlast, out0_valid, out1_valid, out0_ready, out1_ready;

    // Driver and scoreboard state
    beat_t                         drive_beat [stream_pkg::N_INPUTS];
    logic [stream_pkg::N_INPUTS-1:0] drive_valid;
    logic [stream_pkg::N_INPUTS-1:0] in_ready;
    beat_t                         out_beat [2];
    logic [1:0]                    out_valid;
    logic [1:0]                    out_ready;
    beat_t                         expected [2][$];
    integer                        seed;
    logic                          stall_mode;
    int                            timeout_cycles = 1000;

    assign {in0_data, in0_dest, in0_user, in0_tlast} = drive_beat[0];
    assign {in1_data, in1_dest, in1_user, in1_tlast} = drive_beat[1];
    assign {in2_data, in2_dest, in2_user, in2_tlast} = drive_beat[2];
    assign {in3_data, in3_dest, in3_user, in3_tlast} = drive_beat[3];
    assign {in3_valid, in2_valid, in1_valid, in0_valid} = drive_valid;
    assign in_ready = {in3_ready, in2_ready, in1_ready, in0_ready};
    assign out_beat[0] = {out0_data, out0_dest, out0_user, out0_tlast};
    assign out_beat[1] = {out1_data, out1_dest, out1_user, out1_tlast};
    assign out_valid = {out1_valid, out0_valid};
    assign {out1_ready, out0_ready} = out_ready;

    stream_switch_top u_stream_switch_top (.*);

    always #5 clock = ~clock;

    // Prints why the run stops and ends it as failed
    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    // Sends one packet on the input the mux follows while idle
    // The route comes from dest bit 0 of the first beat only
    task automatic send_packet(input control_pkg::route_t route, input logic allow_switch);
        int len;
        int src;
        int waited;
        beat_t beat;
        len = 1 + ($random(seed) & 255) % 6;
        src = int'(select);
        for (int i = 0; i < len; i++) begin
            // A select move inside a packet may only steer the next packet
            if (allow_switch && i == 1 && ($random(seed) & 1) == 1) begin
                select = stream_pkg::SELECT_WIDTH'($random(seed));
                // The new input offers a beat at once and has to wait for tlast
                if (int'(select) != src) begin
                    drive_valid[select] = 1'b1;
                end
            end
            beat = beat_t'({$random(seed), $random(seed)});
            if (i == 0) begin
                beat[stream_pkg::USER_WIDTH+1] = route;
            end
            beat[0] = (i == len - 1);
            drive_beat[src] = beat;
            drive_valid[src] = 1'b1;
            waited = 0;
            @(negedge clock);
            while (!in_ready[src]) begin
                waited++;
                if (waited > timeout_cycles) begin
                    stop_run($sformatf("Timed out waiting for ready on input %0d", src));
                end
                @(negedge clock);
            end
            // Ready is settled by the falling edge, the beat moves on the next rising one
            expected[route].push_back(beat);
            @(posedge clock);
            #1;
            drive_valid[src] = 1'b0;
        end
        // Between packets no input offers anything
        drive_valid = '0;
    endtask

    // Output ready, free running or mostly low so the FIFO fills up
    always begin
        @(posedge clock);
        #1;
        if (stall_mode) begin
            out_ready[0] = ($random(seed) & 3) == 0;
            out_ready[1] = ($random(seed) & 3) == 0;
        end else begin
            out_ready = 2'b11;
        end
    end

    // Every output beat must match the front of its queue
    always @(negedge clock) begin
        if (reset) begin
            assert (out_valid != 2'b11)
                else stop_run($sformatf("FAILED at %0d ns: both outputs valid", $time));
            for (int p = 0; p < 2; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    assert (expected[p].size() > 0 && expected[p][0] == out_beat[p])
                        else stop_run($sformatf("FAILED at %0d ns: output %0d beat %h not expected",
                                                $time, p, out_beat[p]));
                    expected[p].delete(0);
                end
            end
        end
    end

    initial begin
        int waited;
        seed = 39;
        clock = 1'b0;
        reset = 1'b0;
        select = '0;
        drive_valid = '0;
        out_ready = 2'b11;
        stall_mode = 1'b0;
        for (int i = 0; i < stream_pkg::N_INPUTS; i++) begin
            drive_beat[i] = '0;
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;
        // Nothing is offered or accepted before the first packet
        repeat (3) begin
            @(negedge clock);
            assert (out_valid == 2'b00 && in_ready == '0)
                else stop_run($sformatf("FAILED at %0d ns: valid or ready high after reset",
                                        $time));
        end
        @(posedge clock);
        #1;
        // Fixed select, outputs always ready, dest alternating
        for (int p = 0; p < 8; p++) begin
            send_packet(control_pkg::route_t'(p[0]), 1'b0);
        end
        // Same traffic with select moves inside packets
        for (int p = 0; p < 16; p++) begin
            send_packet(control_pkg::route_t'(p[0]), 1'b1);
        end
        // Random dest under heavy back-pressure on both outputs
        stall_mode = 1'b1;
        for (int p = 0; p < 40; p++) begin
            send_packet(control_pkg::route_t'(1'($random(seed))), 1'b1);
        end
        stall_mode = 1'b0;
        waited = 0;
        while (expected[0].size() + expected[1].size() != 0) begin
            waited++;
            if (waited > timeout_cycles) begin
                stop_run("Timed out waiting for the outputs to drain");
            end
            @(negedge clock);
        end
        // Idle tail so a repeated beat would still be seen
        repeat (20) @(negedge clock);
        $display("Test passed");
        $finish;
    end

endmodule

/* sim.f */
design/stream_pkg.sv
design/control_pkg.sv
design/axi_stream.sv
design/axi_stream_mux_4.sv
design/stream_fifo.sv
design/stream_dest_router.sv
design/stream_switch_top.sv
tests/stream_switch_properties.sv
tests/stream_switch_tb.sv

/* Makefile */
# Verilator flow for the stream switch

VERILATOR ?= verilator
TOP       ?= stream_switch_tb
FILE_LIST ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

# The run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
